// ==== source/riscv_pkg.sv ====
// Shared widths and enumerations for the memory and writeback end
// of the RV32 integer pipeline
`default_nettype none

package riscv_pkg;

	// Datapath, address and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// Source of the value written back to rd
	typedef enum logic [1:0] {
		SRC_ALU = 2'd0,
		SRC_MEM = 2'd1,
		SRC_PC4 = 2'd2,
		SRC_IMM = 2'd3
	} result_src_t;

	// Memory controller states, one per handshake phase
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_REQ     = 2'd1,
		ST_RELEASE = 2'd2,
		ST_DONE    = 2'd3
	} mem_state_t;

	// Data memory operation
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_t;

endpackage

`default_nettype wire

// ==== source/riscv_mem_if.sv ====
// Four-phase req/ack bus between the memory controller and the data memory
`timescale 1ns/1ps
`default_nettype none

interface riscv_mem_if
	import riscv_pkg::*;
();

	// Request side, held steady while req is high
	logic            req;
	mem_op_t         op;
	logic [XLEN-1:0] addr;
	logic [XLEN-1:0] wdata;

	// Response side, rdata valid from the rise of ack
	logic            ack;
	logic [XLEN-1:0] rdata;

	modport ctrl (
		output req,
		output op,
		output addr,
		output wdata,
		input  ack,
		input  rdata
	);

	modport mem (
		input  req,
		input  op,
		input  addr,
		input  wdata,
		output ack,
		output rdata
	);

endinterface

`default_nettype wire

// ==== source/riscv_wait_timer.sv ====
// Loadable down-counter that times the data memory access latency
`timescale 1ns/1ps
`default_nettype none

module riscv_wait_timer #(
	parameter int LATENCY = 2
) (
	input  wire  i_clk,
	input  wire  i_rstn,
	input  wire  i_start,
	output logic o_expired
);

	localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

	logic [CNT_W-1:0] count;
	logic             armed;

	// High once the loaded count has run out, until the next start
	assign o_expired = armed && (count == '0);

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			count <= '0;
			armed <= 1'b0;
		end else begin
			if (i_start) begin
				count <= CNT_W'(LATENCY - 1);
				armed <= 1'b1;
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
		end
	end

	// The memory must not restart the timer mid-count
	a_start_when_idle: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_start |-> (count == '0));

endmodule

`default_nettype wire

// ==== source/riscv_mem_ctrl.sv ====
// Memory controller FSM: runs the four-phase handshake for loads and stores,
// stalls upstream and issues one pipeline register enable per instruction
`timescale 1ns/1ps
`default_nettype none

module riscv_mem_ctrl
	import riscv_pkg::*;
(
	input  wire              i_clk,
	input  wire              i_rstn,
	input  wire              i_valid,
	input  wire              i_mem_rd_en,
	input  wire              i_mem_wr_en,
	input  wire [XLEN-1:0]   i_addr,
	input  wire [XLEN-1:0]   i_wdata,
	output logic             o_stall,
	output logic             o_mw_en,
	riscv_mem_if.ctrl        mem_bus
);

	mem_state_t state;
	logic       mem_op;

	assign mem_op = i_mem_rd_en | i_mem_wr_en;

	// Stall covers the phases where the access is still in flight
	assign o_stall = (state == ST_REQ) || (state == ST_RELEASE);

	// Non-memory instructions pass straight through, memory ones finish in ST_DONE
	assign o_mw_en = ((state == ST_IDLE) && i_valid && !mem_op) || (state == ST_DONE);

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state         <= ST_IDLE;
			mem_bus.req   <= 1'b0;
			mem_bus.op    <= OP_READ;
			mem_bus.addr  <= '0;
			mem_bus.wdata <= '0;
		end else begin
			unique case (state)
				ST_IDLE: begin
					if (i_valid && mem_op) begin
						// A store wins if both enables are set
						mem_bus.op    <= i_mem_wr_en ? OP_WRITE : OP_READ;
						mem_bus.addr  <= i_addr;
						mem_bus.wdata <= i_wdata;
						mem_bus.req   <= 1'b1;
						state         <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (mem_bus.ack) begin
						mem_bus.req <= 1'b0;
						state       <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					// Wait for the memory to close the handshake
					if (!mem_bus.ack) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// A new request only starts once the memory has dropped ack
	a_req_after_ack_low: assert property (@(posedge i_clk) disable iff (!i_rstn)
		$rose(mem_bus.req) |-> !mem_bus.ack);

	// The pipeline register is enabled only while the memory bus is idle
	a_no_en_during_access: assert property (@(posedge i_clk) disable iff (!i_rstn)
		o_mw_en |-> !mem_bus.req && !mem_bus.ack);

endmodule

`default_nettype wire

// ==== source/riscv_data_mem.sv ====
// Word-addressed data memory answering the four-phase handshake
// after a fixed latency counted by the wait timer
`timescale 1ns/1ps
`default_nettype none

module riscv_data_mem
	import riscv_pkg::*;
#(
	parameter int MEM_LATENCY    = 2,
	parameter int MEM_DEPTH_LOG2 = 8
) (
	input  wire       i_clk,
	input  wire       i_rstn,
	riscv_mem_if.mem  mem_bus
);

	localparam int DEPTH = 1 << MEM_DEPTH_LOG2;

	logic [XLEN-1:0]           mem [DEPTH];
	logic [MEM_DEPTH_LOG2-1:0] word_addr;
	logic                      req_q;
	logic                      busy;
	logic                      start;
	logic                      expired;

	// Byte offset bits are dropped, accesses are whole words
	assign word_addr = mem_bus.addr[MEM_DEPTH_LOG2+1:2];

	// Rising edge of req opens a new access
	assign start = mem_bus.req && !req_q;

	riscv_wait_timer #(
		.LATENCY(MEM_LATENCY)
	) u_wait_timer (
		.i_clk    (i_clk),
		.i_rstn   (i_rstn),
		.i_start  (start),
		.o_expired(expired)
	);

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			req_q         <= 1'b0;
			busy          <= 1'b0;
			mem_bus.ack   <= 1'b0;
			mem_bus.rdata <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else begin
			req_q <= mem_bus.req;
			if (start) begin
				busy <= 1'b1;
			end else if (busy && expired) begin
				busy        <= 1'b0;
				mem_bus.ack <= 1'b1;
				if (mem_bus.op == OP_WRITE) begin
					mem[word_addr] <= mem_bus.wdata;
				end else begin
					mem_bus.rdata <= mem[word_addr];
				end
			end else if (mem_bus.ack && !mem_bus.req) begin
				mem_bus.ack <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/riscv_mw_register.sv ====
// Memory-to-writeback pipeline register, loads all fields on enable
`timescale 1ns/1ps
`default_nettype none

module riscv_mw_register
	import riscv_pkg::*;
#(
	parameter logic [XLEN-1:0] REGISTER_INIT = '0
) (
	input  wire                    i_clk,
	input  wire                    i_rstn,
	input  wire                    i_mw_register_en,

	input  wire result_src_t       i_mw_register_src_rd,
	input  wire                    i_mw_register_reg_wr_en,
	input  wire [XLEN-1:0]         i_mw_register_alu_result,
	input  wire [XLEN-1:0]         i_mw_register_rd_data,
	input  wire [REG_ADDR_W-1:0]   i_mw_register_rd_addr,
	input  wire [XLEN-1:0]         i_mw_register_pcplus4,
	input  wire [XLEN-1:0]         i_mw_register_imm_ext,

	output result_src_t            o_mw_register_src_rd,
	output logic                   o_mw_register_reg_wr_en,
	output logic [XLEN-1:0]        o_mw_register_alu_result,
	output logic [XLEN-1:0]        o_mw_register_rd_data,
	output logic [REG_ADDR_W-1:0]  o_mw_register_rd_addr,
	output logic [XLEN-1:0]        o_mw_register_pcplus4,
	output logic [XLEN-1:0]        o_mw_register_imm_ext
);

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			o_mw_register_src_rd     <= result_src_t'(REGISTER_INIT[1:0]);
			o_mw_register_reg_wr_en  <= REGISTER_INIT[0];
			o_mw_register_alu_result <= REGISTER_INIT;
			o_mw_register_rd_data    <= REGISTER_INIT;
			o_mw_register_rd_addr    <= REGISTER_INIT[REG_ADDR_W-1:0];
			o_mw_register_pcplus4    <= REGISTER_INIT;
			o_mw_register_imm_ext    <= REGISTER_INIT;
		end else if (i_mw_register_en) begin
			// Fields hold between enables
			o_mw_register_src_rd     <= i_mw_register_src_rd;
			o_mw_register_reg_wr_en  <= i_mw_register_reg_wr_en;
			o_mw_register_alu_result <= i_mw_register_alu_result;
			o_mw_register_rd_data    <= i_mw_register_rd_data;
			o_mw_register_rd_addr    <= i_mw_register_rd_addr;
			o_mw_register_pcplus4    <= i_mw_register_pcplus4;
			o_mw_register_imm_ext    <= i_mw_register_imm_ext;
		end
	end

endmodule

`default_nettype wire

// ==== source/riscv_regfile.sv ====
// Writeback result selector and 32-entry register file,
// x0 hardwired to zero, combinational read port
`timescale 1ns/1ps
`default_nettype none

module riscv_regfile
	import riscv_pkg::*;
(
	input  wire                    i_clk,
	input  wire                    i_rstn,
	input  wire result_src_t       i_src_rd,
	input  wire                    i_reg_wr_en,
	input  wire [XLEN-1:0]         i_alu_result,
	input  wire [XLEN-1:0]         i_rd_data,
	input  wire [XLEN-1:0]         i_pcplus4,
	input  wire [XLEN-1:0]         i_imm_ext,
	input  wire [REG_ADDR_W-1:0]   i_rd_addr,
	input  wire                    i_wb_valid,
	input  wire [REG_ADDR_W-1:0]   i_rs_addr,
	output logic [XLEN-1:0]        o_rs_data
);

	localparam int NUM_REGS = 1 << REG_ADDR_W;

	logic [XLEN-1:0] regs [NUM_REGS];
	logic [XLEN-1:0] wb_data;
	logic            wb_write;

	always_comb begin
		unique case (i_src_rd)
			SRC_ALU: wb_data = i_alu_result;
			SRC_MEM: wb_data = i_rd_data;
			SRC_PC4: wb_data = i_pcplus4;
			SRC_IMM: wb_data = i_imm_ext;
		endcase
	end

	// One write per pulse of the delayed enable, never into x0
	assign wb_write = i_wb_valid && i_reg_wr_en && (i_rd_addr != '0);

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_write) begin
			regs[i_rd_addr] <= wb_data;
		end
	end

	// x0 is never written and so always reads its reset value of zero
	assign o_rs_data = regs[i_rs_addr];

endmodule

`default_nettype wire

// ==== source/riscv_mem_wb.sv ====
// Memory and writeback top: controller, data memory, MW pipeline register
// and register file around one req/ack memory bus
`timescale 1ns/1ps
`default_nettype none

module riscv_mem_wb
	import riscv_pkg::*;
#(
	parameter int MEM_LATENCY    = 2,
	parameter int MEM_DEPTH_LOG2 = 8
) (
	input  wire                    i_clk,
	input  wire                    i_rstn,
	input  wire                    i_valid,
	input  wire [1:0]              i_src_rd,
	input  wire                    i_reg_wr_en,
	input  wire                    i_mem_rd_en,
	input  wire                    i_mem_wr_en,
	input  wire [XLEN-1:0]         i_alu_result,
	input  wire [XLEN-1:0]         i_store_data,
	input  wire [XLEN-1:0]         i_imm_ext,
	input  wire [XLEN-1:0]         i_pcplus4,
	input  wire [REG_ADDR_W-1:0]   i_rd_addr,
	input  wire [REG_ADDR_W-1:0]   i_rs_addr,
	output logic [XLEN-1:0]        o_rs_data,
	output logic                   o_stall
);

	riscv_mem_if mem_bus ();

	logic                  mw_en;
	logic                  wb_valid;
	result_src_t           mw_src_rd;
	logic                  mw_reg_wr_en;
	logic [XLEN-1:0]       mw_alu_result;
	logic [XLEN-1:0]       mw_rd_data;
	logic [REG_ADDR_W-1:0] mw_rd_addr;
	logic [XLEN-1:0]       mw_pcplus4;
	logic [XLEN-1:0]       mw_imm_ext;

	riscv_mem_ctrl u_mem_ctrl (
		.i_clk      (i_clk),
		.i_rstn     (i_rstn),
		.i_valid    (i_valid),
		.i_mem_rd_en(i_mem_rd_en),
		.i_mem_wr_en(i_mem_wr_en),
		.i_addr     (i_alu_result),
		.i_wdata    (i_store_data),
		.o_stall    (o_stall),
		.o_mw_en    (mw_en),
		.mem_bus    (mem_bus.ctrl)
	);

	riscv_data_mem #(
		.MEM_LATENCY   (MEM_LATENCY),
		.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)
	) u_data_mem (
		.i_clk  (i_clk),
		.i_rstn (i_rstn),
		.mem_bus(mem_bus.mem)
	);

	// Load data comes from the memory's held rdata
	riscv_mw_register u_mw_register (
		.i_clk                   (i_clk),
		.i_rstn                  (i_rstn),
		.i_mw_register_en        (mw_en),
		.i_mw_register_src_rd    (result_src_t'(i_src_rd)),
		.i_mw_register_reg_wr_en (i_reg_wr_en),
		.i_mw_register_alu_result(i_alu_result),
		.i_mw_register_rd_data   (mem_bus.rdata),
		.i_mw_register_rd_addr   (i_rd_addr),
		.i_mw_register_pcplus4   (i_pcplus4),
		.i_mw_register_imm_ext   (i_imm_ext),
		.o_mw_register_src_rd    (mw_src_rd),
		.o_mw_register_reg_wr_en (mw_reg_wr_en),
		.o_mw_register_alu_result(mw_alu_result),
		.o_mw_register_rd_data   (mw_rd_data),
		.o_mw_register_rd_addr   (mw_rd_addr),
		.o_mw_register_pcplus4   (mw_pcplus4),
		.o_mw_register_imm_ext   (mw_imm_ext)
	);

	// Writeback happens one edge after the MW register captures
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= mw_en;
		end
	end

	riscv_regfile u_regfile (
		.i_clk       (i_clk),
		.i_rstn      (i_rstn),
		.i_src_rd    (mw_src_rd),
		.i_reg_wr_en (mw_reg_wr_en),
		.i_alu_result(mw_alu_result),
		.i_rd_data   (mw_rd_data),
		.i_pcplus4   (mw_pcplus4),
		.i_imm_ext   (mw_imm_ext),
		.i_rd_addr   (mw_rd_addr),
		.i_wb_valid  (wb_valid),
		.i_rs_addr   (i_rs_addr),
		.o_rs_data   (o_rs_data)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_riscv_mem_wb.sv ====
// Testbench for the memory and writeback stages, table driven
// with a register and store model that gives the expected results
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_mem_wb
	import riscv_pkg::*;
();

	localparam int MEM_LATENCY = 2;
	localparam int DEPTH_LOG2  = 8;

	// Word addresses used by the load and store entries
	localparam logic [XLEN-1:0] ADDR_A = 32'h0000_0040;
	localparam logic [XLEN-1:0] ADDR_B = 32'h0000_01f8;
	localparam logic [XLEN-1:0] ADDR_C = 32'h0000_0324;

	typedef struct packed {
		logic            valid;
		result_src_t     src;
		logic            reg_wr;
		logic            mem_rd;
		logic            mem_wr;
		logic [XLEN-1:0] alu;
		logic [XLEN-1:0] store;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc4;
		logic [4:0]      rd;
		logic [4:0]      rs;
		logic [XLEN-1:0] expected;
	} instr_t;

	logic            i_clk;
	logic            i_rstn;
	logic            i_valid;
	logic [1:0]      i_src_rd;
	logic            i_reg_wr_en;
	logic            i_mem_rd_en;
	logic            i_mem_wr_en;
	logic [XLEN-1:0] i_alu_result;
	logic [XLEN-1:0] i_store_data;
	logic [XLEN-1:0] i_imm_ext;
	logic [XLEN-1:0] i_pcplus4;
	logic [4:0]      i_rd_addr;
	logic [4:0]      i_rs_addr;
	logic [XLEN-1:0] o_rs_data;
	logic            o_stall;

	instr_t          table_q[$];
	string           note_q[$];
	bit              fail_q[$];
	logic [XLEN-1:0] reg_model [32];
	logic [XLEN-1:0] store_ref [1 << DEPTH_LOG2];
	integer          seed;
	int              pass_count;
	int              fail_count;
	int              cycle_count;
	int              cycle_limit;

	riscv_mem_wb #(
		.MEM_LATENCY   (MEM_LATENCY),
		.MEM_DEPTH_LOG2(DEPTH_LOG2)
	) uut (
		.i_clk       (i_clk),
		.i_rstn      (i_rstn),
		.i_valid     (i_valid),
		.i_src_rd    (i_src_rd),
		.i_reg_wr_en (i_reg_wr_en),
		.i_mem_rd_en (i_mem_rd_en),
		.i_mem_wr_en (i_mem_wr_en),
		.i_alu_result(i_alu_result),
		.i_store_data(i_store_data),
		.i_imm_ext   (i_imm_ext),
		.i_pcplus4   (i_pcplus4),
		.i_rd_addr   (i_rd_addr),
		.i_rs_addr   (i_rs_addr),
		.o_rs_data   (o_rs_data),
		.o_stall     (o_stall)
	);

	always #2 i_clk = ~i_clk;

	// Appends one entry and updates the model to get the expected read value
	task automatic add_instr(input string note, input logic v, input result_src_t src,
		input logic wr, input logic ld, input logic st, input logic [4:0] rd,
		input logic [4:0] rs, input logic [XLEN-1:0] addr);
		instr_t          e;
		logic [XLEN-1:0] load_value;
		logic [XLEN-1:0] wb_value;
		e.valid  = v;
		e.src    = src;
		e.reg_wr = wr;
		e.mem_rd = ld;
		e.mem_wr = st;
		e.alu    = (ld || st) ? addr : $random(seed);
		e.store  = $random(seed);
		e.imm    = $random(seed);
		e.pc4    = $random(seed) & 32'hffff_fffc;
		e.rd     = rd;
		e.rs     = rs;
		load_value = store_ref[addr[DEPTH_LOG2+1:2]];
		if (v) begin
			if (st) begin
				store_ref[addr[DEPTH_LOG2+1:2]] = e.store;
			end
			case (src)
				SRC_ALU: wb_value = e.alu;
				SRC_MEM: wb_value = load_value;
				SRC_PC4: wb_value = e.pc4;
				SRC_IMM: wb_value = e.imm;
			endcase
			if (wr && rd != 5'd0) begin
				reg_model[rd] = wb_value;
			end
		end
		e.expected = (rs == 5'd0) ? '0 : reg_model[rs];
		table_q.push_back(e);
		note_q.push_back(note);
		fail_q.push_back(1'b0);
	endtask

	task automatic build_table();
		add_instr("alu to x1", 1'b1, SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd1, 5'd1, '0);
		add_instr("pc+4 to x2", 1'b1, SRC_PC4, 1'b1, 1'b0, 1'b0, 5'd2, 5'd2, '0);
		add_instr("imm to x3", 1'b1, SRC_IMM, 1'b1, 1'b0, 1'b0, 5'd3, 5'd3, '0);
		add_instr("alu without write", 1'b1, SRC_ALU, 1'b0, 1'b0, 1'b0, 5'd4, 5'd4, '0);
		add_instr("imm without write", 1'b1, SRC_IMM, 1'b0, 1'b0, 1'b0, 5'd1, 5'd1, '0);
		add_instr("alu to x0", 1'b1, SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd0, 5'd0, '0);
		add_instr("imm to x0", 1'b1, SRC_IMM, 1'b1, 1'b0, 1'b0, 5'd0, 5'd0, '0);
		add_instr("store A", 1'b1, SRC_ALU, 1'b0, 1'b0, 1'b1, 5'd5, 5'd5, ADDR_A);
		add_instr("load A to x6", 1'b1, SRC_MEM, 1'b1, 1'b1, 1'b0, 5'd6, 5'd6, ADDR_A);
		add_instr("store B", 1'b1, SRC_ALU, 1'b0, 1'b0, 1'b1, 5'd7, 5'd7, ADDR_B);
		add_instr("load B to x8", 1'b1, SRC_MEM, 1'b1, 1'b1, 1'b0, 5'd8, 5'd8, ADDR_B);
		add_instr("load A to x9", 1'b1, SRC_MEM, 1'b1, 1'b1, 1'b0, 5'd9, 5'd9, ADDR_A);
		add_instr("store A again", 1'b1, SRC_ALU, 1'b0, 1'b0, 1'b1, 5'd5, 5'd6, ADDR_A);
		add_instr("load A to x10", 1'b1, SRC_MEM, 1'b1, 1'b1, 1'b0, 5'd10, 5'd10, ADDR_A);
		// Non-memory run, one instruction per cycle
		add_instr("alu to x11", 1'b1, SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd11, 5'd11, '0);
		add_instr("pc+4 to x12", 1'b1, SRC_PC4, 1'b1, 1'b0, 1'b0, 5'd12, 5'd12, '0);
		add_instr("imm to x13", 1'b1, SRC_IMM, 1'b1, 1'b0, 1'b0, 5'd13, 5'd13, '0);
		add_instr("alu to x14", 1'b1, SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd14, 5'd14, '0);
		add_instr("imm to x15", 1'b1, SRC_IMM, 1'b1, 1'b0, 1'b0, 5'd15, 5'd15, '0);
		add_instr("alu to x11 again", 1'b1, SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd11, 5'd11, '0);
		add_instr("alu to x17", 1'b1, SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd17, 5'd17, '0);
		add_instr("load unwritten C", 1'b1, SRC_MEM, 1'b1, 1'b1, 1'b0, 5'd17, 5'd17, ADDR_C);
		// Entries with valid low must change nothing
		add_instr("idle alu to x1", 1'b0, SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd1, 5'd1, '0);
		add_instr("idle store A", 1'b0, SRC_ALU, 1'b0, 1'b0, 1'b1, 5'd0, 5'd10, ADDR_A);
		add_instr("load A to x18", 1'b1, SRC_MEM, 1'b1, 1'b1, 1'b0, 5'd18, 5'd18, ADDR_A);
		add_instr("idle load to x18", 1'b0, SRC_MEM, 1'b1, 1'b1, 1'b0, 5'd18, 5'd18, ADDR_B);
	endtask

	task automatic drive_instr(input instr_t e, input logic [4:0] rs);
		i_valid      = e.valid;
		i_src_rd     = e.src;
		i_reg_wr_en  = e.reg_wr;
		i_mem_rd_en  = e.mem_rd;
		i_mem_wr_en  = e.mem_wr;
		i_alu_result = e.alu;
		i_store_data = e.store;
		i_imm_ext    = e.imm;
		i_pcplus4    = e.pc4;
		i_rd_addr    = e.rd;
		i_rs_addr    = rs;
	endtask

	task automatic report_test(input string note, input bit bad);
		if (bad) begin
			fail_count++;
			$display("test %s: failed", note);
		end else begin
			pass_count++;
			$display("test %s: ok", note);
		end
	endtask

	task automatic check_result(input int idx);
		assert (o_rs_data === table_q[idx].expected) else begin
			$display("ERR o_rs_data x%0d expected %h got %h",
				table_q[idx].rs, table_q[idx].expected, o_rs_data);
			fail_q[idx] = 1'b1;
		end
		report_test(note_q[idx], fail_q[idx]);
	endtask

	// Stall must be low and every register must read zero
	task automatic check_reset();
		bit bad;
		bad = 1'b0;
		assert (o_stall === 1'b0) else begin
			$display("ERR o_stall expected 0 got %h after reset", o_stall);
			bad = 1'b1;
		end
		for (int r = 0; r < 32; r++) begin
			i_rs_addr = 5'(r);
			@(negedge i_clk);
			assert (o_rs_data === '0) else begin
				$display("ERR o_rs_data x%0d expected %h got %h", r, 32'h0, o_rs_data);
				bad = 1'b1;
			end
			@(posedge i_clk);
			#1;
		end
		report_test("reset", bad);
	endtask

	// The read port shows the previous entry while the next one is presented
	task automatic run_table();
		instr_t e;
		int     prev;
		prev = -1;
		for (int i = 0; i < table_q.size(); i++) begin
			e = table_q[i];
			drive_instr(e, (prev < 0) ? 5'd0 : table_q[prev].rs);
			@(posedge i_clk);
			#1;
			if (prev >= 0) begin
				check_result(prev);
			end
			if (e.valid && (e.mem_rd || e.mem_wr)) begin
				assert (o_stall === 1'b1) else begin
					$display("ERR o_stall expected 1 got %h after memory request", o_stall);
					fail_q[i] = 1'b1;
				end
				while (o_stall === 1'b1) begin
					@(posedge i_clk);
					#1;
				end
				// Controller is in ST_DONE, the next edge captures the result
				@(posedge i_clk);
				#1;
			end
			assert (o_stall === 1'b0) else begin
				$display("ERR o_stall expected 0 got %h after completion", o_stall);
				fail_q[i] = 1'b1;
			end
			prev = i;
		end
		drive_instr('0, table_q[prev].rs);
		@(posedge i_clk);
		#1;
		check_result(prev);
	endtask

	initial begin
		cycle_count = 0;
		@(posedge i_clk);
		while (cycle_count < cycle_limit) begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		seed       = 32'hd421;
		pass_count = 0;
		fail_count = 0;
		i_clk      = 1'b0;
		i_rstn     = 1'b0;
		drive_instr('0, 5'd0);
		for (int r = 0; r < 32; r++) begin
			reg_model[r] = '0;
		end
		for (int w = 0; w < (1 << DEPTH_LOG2); w++) begin
			store_ref[w] = '0;
		end
		build_table();
		cycle_limit = table_q.size() * (MEM_LATENCY + 6) + 20;
		repeat (3) @(posedge i_clk);
		#1;
		i_rstn = 1'b1;
		check_reset();
		run_table();
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
source/riscv_pkg.sv
source/riscv_mem_if.sv
source/riscv_wait_timer.sv
source/riscv_mem_ctrl.sv
source/riscv_data_mem.sv
source/riscv_mw_register.sv
source/riscv_regfile.sv
source/riscv_mem_wb.sv
testbench/tb_riscv_mem_wb.sv

// ==== Makefile ====
TOP := tb_riscv_mem_wb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
